// File: include/lvdsTx_cfg.svh
`ifndef LVDS_TX_CFG_SVH
`define LVDS_TX_CFG_SVH

// Link geometry, fixed by the FPD-Link 18-bit format
`define LVDS_WORD_BITS 7      // Bits per lane per pixel
`define LVDS_DATA_LANES 3     // RGB plus sync lanes
`define LVDS_LANES 4          // Data lanes plus clock lane
`define LVDS_PHASES 7         // Pair cycles per two-pixel window

// Pixel slot request phases within one window
`define LVDS_SLOT_A_PHASE 1
`define LVDS_SLOT_B_PHASE 4

// Clock-lane word, bit 0 goes out first
`define LVDS_CLK_PATTERN 7'b1100011

`endif

// File: src/linkPkg.sv
`include "lvdsTx_cfg.svh"

// Link-side types shared by the phase generator, mapper and serializers
package linkPkg;

   // One lane's slice of one pixel
   typedef logic [`LVDS_WORD_BITS-1:0] laneWord_t;

   // Pair-cycle counter, 0 to 6
   typedef logic [$clog2(`LVDS_PHASES)-1:0] phase_t;

   // Bits driven to the DDR pad cell in one fast cycle
   typedef struct packed {
      logic early;   // Sent first
      logic late;    // Sent second
   } bitPair_t;

   // Per-lane words, lane 3 is the clock lane
   typedef laneWord_t [`LVDS_LANES-1:0] laneWords_t;

   // Per-lane output pairs
   typedef bitPair_t [`LVDS_LANES-1:0] lanePairs_t;

endpackage

// File: src/pixelPkg.sv
// Pixel-side types seen by the video source
package pixelPkg;

   // 6-bit color component, 18-bit mode
   typedef logic [5:0] color_t;

   typedef struct packed {
      color_t red;
      color_t green;
      color_t blue;
   } pixel_t;

   // Timing controls carried on lane 2
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic de;       // Data enable, low during blanking
   } sync_t;

endpackage

// File: src/phaseGen.sv
`timescale 1ns/1ns
`include "lvdsTx_cfg.svh"

module phaseGen (
   input  logic            clk,
   input  logic            rst,
   output linkPkg::phase_t phase,
   output logic            pixelReq,
   output logic            wordLoad,
   output logic            linkActive
);
   import linkPkg::*;

   localparam phase_t LAST_PHASE = phase_t'(`LVDS_PHASES - 1);
   localparam phase_t SLOT_A     = phase_t'(`LVDS_SLOT_A_PHASE);
   localparam phase_t SLOT_B     = phase_t'(`LVDS_SLOT_B_PHASE);

   ////////////////////////////////////////
   // Window counter
   ////////////////////////////////////////

   // One counter for every lane, so lanes stay locked
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         phase <= '0;
      else if (phase == LAST_PHASE)
         phase <= '0;                  // Wrap, new window
      else
         phase <= phase + 1'b1;
   end

   // Two pixels per window, spaced 3 then 4 cycles
   assign pixelReq = (phase == SLOT_A) || (phase == SLOT_B);

   // Last phase hands staged words to the serializers
   assign wordLoad = (phase == LAST_PHASE);

   ////////////////////////////////////////
   // Link status
   ////////////////////////////////////////

   // Set once the first window is buffered, then sticky
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         linkActive <= 1'b0;
      else if (wordLoad)
         linkActive <= 1'b1;
   end

endmodule

// File: src/pixelMapper.sv
`timescale 1ns/1ns
`include "lvdsTx_cfg.svh"

module pixelMapper (
   input  logic                clk,
   input  logic                rst,
   input  linkPkg::phase_t     phase,
   input  logic                pixelReq,
   input  pixelPkg::pixel_t    pixel,
   input  pixelPkg::sync_t     sync,
   output linkPkg::laneWords_t stageA,
   output linkPkg::laneWords_t stageB
);
   import linkPkg::*;
   import pixelPkg::*;

   localparam phase_t SLOT_A = phase_t'(`LVDS_SLOT_A_PHASE);

   // Data lanes only, clock lane is constant
   typedef laneWord_t [`LVDS_DATA_LANES-1:0] dataWords_t;

   dataWords_t packedPix;   // Current pixel in lane order
   dataWords_t stageDataA;  // First pixel of the window
   dataWords_t stageDataB;  // Second pixel of the window

   ////////////////////////////////////////
   // Lane map
   ////////////////////////////////////////

   // Bit 0 of each word is the first bit on the wire
   function automatic dataWords_t packPixel(input pixel_t px, input sync_t sy);
      pixel_t     vis;
      dataWords_t w;
      vis = sy.de ? px : '0;                            // Blank colors
      w[0] = {vis.green[0], vis.red};                   // R0..R5, G0
      w[1] = {vis.blue[1:0], vis.green[5:1]};           // G1..G5, B0, B1
      w[2] = {sy.de, sy.vsync, sy.hsync, vis.blue[5:2]}; // B2..B5, HS, VS, DE
      return w;
   endfunction

   assign packedPix = packPixel(pixel, sync);

   ////////////////////////////////////////
   // Slot capture
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         stageDataA <= '0;
         stageDataB <= '0;
      end
      else if (pixelReq)
      begin
         // Request phase picks the slot
         if (phase == SLOT_A)
            stageDataA <= packedPix;
         else
            stageDataB <= packedPix;
      end
   end

   // Clock lane sits on top, index 3
   assign stageA = {`LVDS_CLK_PATTERN, stageDataA};
   assign stageB = {`LVDS_CLK_PATTERN, stageDataB};

endmodule

// File: src/laneSerializer.sv
`timescale 1ns/1ns

module laneSerializer (
   input  logic               clk,
   input  logic               rst,
   input  linkPkg::phase_t    phase,
   input  logic               wordLoad,
   input  logic               linkActive,
   input  linkPkg::laneWord_t wordA,
   input  linkPkg::laneWord_t wordB,
   output linkPkg::bitPair_t  pair
);
   import linkPkg::*;

   laneWord_t sendBuf [2];  // 14 bits, two pixels
   bitPair_t  nextPair;     // Pair selected for this phase

   ////////////////////////////////////////
   // Send buffer
   ////////////////////////////////////////

   // Both words at once, mapper may refill its stage meanwhile
   always_ff @(posedge clk)
   begin
      if (wordLoad)
      begin
         sendBuf[0] <= wordA;
         sendBuf[1] <= wordB;
      end
   end

   ////////////////////////////////////////
   // Pair selection
   ////////////////////////////////////////

   // Seven pairs per window, lower bit index goes early
   always_comb
   begin
      nextPair = '0;
      case (phase)
         3'd0:
         begin
            nextPair.early = sendBuf[0][0];
            nextPair.late  = sendBuf[0][1];
         end
         3'd1:
         begin
            nextPair.early = sendBuf[0][2];
            nextPair.late  = sendBuf[0][3];
         end
         3'd2:
         begin
            nextPair.early = sendBuf[0][4];
            nextPair.late  = sendBuf[0][5];
         end
         3'd3:
         begin
            // Straddles the two words
            nextPair.early = sendBuf[0][6];
            nextPair.late  = sendBuf[1][0];
         end
         3'd4:
         begin
            nextPair.early = sendBuf[1][1];
            nextPair.late  = sendBuf[1][2];
         end
         3'd5:
         begin
            nextPair.early = sendBuf[1][3];
            nextPair.late  = sendBuf[1][4];
         end
         3'd6:
         begin
            nextPair.early = sendBuf[1][5];
            nextPair.late  = sendBuf[1][6];
         end
         default:
            nextPair = '0;   // Phase 7 never occurs
      endcase
   end

   // Output pair, quiet until the first window is buffered
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         pair <= '0;
      else if (linkActive)
         pair <= nextPair;
   end

endmodule

// File: src/lvdsTransmitter.sv
`timescale 1ns/1ns
`include "lvdsTx_cfg.svh"

module lvdsTransmitter (
   input  logic                clk,
   input  logic                rst,
   input  pixelPkg::pixel_t    pixel,
   input  pixelPkg::sync_t     sync,
   output logic                pixelReq,
   output logic                linkActive,
   output linkPkg::lanePairs_t lanePairs
);
   import linkPkg::*;

   phase_t     phase;     // Shared window phase
   logic       wordLoad;  // Stage to buffer transfer
   laneWords_t stageA;    // Slot A words, all lanes
   laneWords_t stageB;    // Slot B words, all lanes

   phaseGen uPhaseGen (
      .clk        (clk),
      .rst        (rst),
      .phase      (phase),
      .pixelReq   (pixelReq),
      .wordLoad   (wordLoad),
      .linkActive (linkActive)
   );

   pixelMapper uPixelMapper (
      .clk      (clk),
      .rst      (rst),
      .phase    (phase),
      .pixelReq (pixelReq),
      .pixel    (pixel),
      .sync     (sync),
      .stageA   (stageA),
      .stageB   (stageB)
   );

   // One serializer per lane, clock lane included
   for (genvar lane = 0; lane < `LVDS_LANES; lane++)
   begin : gLane
      laneSerializer uLaneSer (
         .clk        (clk),
         .rst        (rst),
         .phase      (phase),
         .wordLoad   (wordLoad),
         .linkActive (linkActive),
         .wordA      (stageA[lane]),
         .wordB      (stageB[lane]),
         .pair       (lanePairs[lane])
      );
   end

endmodule

// File: dv/lvdsTx_props.sv
`timescale 1ns/1ns
`include "lvdsTx_cfg.svh"

module lvdsTx_props (
   input logic                clk,
   input logic                rst,
   input linkPkg::phase_t     phase,
   input logic                pixelReq,
   input logic                linkActive,
   input linkPkg::lanePairs_t lanePairs
);
   import linkPkg::*;

   // Full clock-lane window, slot B word on top
   localparam logic [2*`LVDS_WORD_BITS-1:0] CLK_FRAME = {`LVDS_CLK_PATTERN, `LVDS_CLK_PATTERN};

   logic     resetFail   = 1'b0;
   logic     quietFail   = 1'b0;
   logic     cadenceFail = 1'b0;
   logic     clockFail   = 1'b0;
   logic     anyFail;         // Polled by the testbench
   int       reqGap;          // Cycles since the last request
   int       lastGap;         // Spacing at the previous request
   logic     seenReq;
   int       pairIdx;         // Window pair now on the lanes
   bitPair_t expClk;

   assign anyFail = resetFail | quietFail | cadenceFail | clockFail;

   ////////////////////////////////////////
   // Request spacing tracker
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         reqGap  <= 0;
         lastGap <= 0;
         seenReq <= 1'b0;
      end
      else if (pixelReq)
      begin
         reqGap  <= 1;
         lastGap <= reqGap;   // Spacing just completed
         seenReq <= 1'b1;
      end
      else
         reqGap <= reqGap + 1;
   end

   // Output lags the phase by one cycle
   always_comb
   begin
      pairIdx      = (phase == '0) ? `LVDS_PHASES - 1 : int'(phase) - 1;
      expClk.early = CLK_FRAME[2*pairIdx];
      expClk.late  = CLK_FRAME[2*pairIdx + 1];
   end

   ////////////////////////////////////////
   // Properties
   ////////////////////////////////////////

   resetState: assert property (@(posedge clk)
      rst |-> !pixelReq && !linkActive && lanePairs == '0)
      else
      begin
         resetFail = 1'b1;
         $error("outputs not idle during reset");
      end

   quietUntilActive: assert property (@(posedge clk) !linkActive |-> lanePairs == '0)
      else
      begin
         quietFail = 1'b1;
         $error("lanePairs driven before linkActive");
      end

   // Spacings 3 and 4 in turn, none missing
   reqCadence: assert property (@(posedge clk) disable iff (rst)
      seenReq |-> (pixelReq ? ((reqGap == 3 || reqGap == 4) && reqGap != lastGap)
                            : (reqGap < 4)))
      else
      begin
         cadenceFail = 1'b1;
         $error("pixelReq cadence broken, gap %0d", reqGap);
      end

   clockLane: assert property (@(posedge clk) disable iff (rst)
      $past(linkActive) |-> lanePairs[3] == expClk)
      else
      begin
         clockFail = 1'b1;
         $error("clock lane pair 0x%0h, expected 0x%0h", lanePairs[3], expClk);
      end

endmodule

bind lvdsTransmitter lvdsTx_props uProps (
   .clk        (clk),
   .rst        (rst),
   .phase      (phase),
   .pixelReq   (pixelReq),
   .linkActive (linkActive),
   .lanePairs  (lanePairs)
);

// File: dv/lvdsTb.sv
`timescale 1ns/1ns
`include "lvdsTx_cfg.svh"

module lvdsTb;
   import linkPkg::*;
   import pixelPkg::*;

   localparam int NUM_PIXELS = 400;
   localparam int CLK_PERIOD = 8;
   // Twice the nominal run at two pixels per seven cycles
   localparam int TIMEOUT_NS = 2 * NUM_PIXELS * 7 * CLK_PERIOD / 2;
   localparam logic [2*`LVDS_WORD_BITS-1:0] CLK_FRAME = {`LVDS_CLK_PATTERN, `LVDS_CLK_PATTERN};

   typedef struct packed {
      pixel_t pix;
      sync_t  sy;
   } sample_t;

   logic       clk = 1'b0;
   logic       rst;
   pixel_t     pixel;
   sync_t      sync;
   logic       pixelReq;
   logic       linkActive;
   lanePairs_t lanePairs;

   sample_t expQ [$];     // Sent pixels in send order
   int      sent = 0;
   int      checked = 0;
   int      frames = 0;   // Clock-lane windows found
   int      sinceFrame = 0;
   logic [`LVDS_LANES-1:0][2*`LVDS_WORD_BITS-1:0] hist = '0;  // Last 14 bits per lane

   lvdsTransmitter uut (
      .clk        (clk),
      .rst        (rst),
      .pixel      (pixel),
      .sync       (sync),
      .pixelReq   (pixelReq),
      .linkActive (linkActive),
      .lanePairs  (lanePairs)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   ////////////////////////////////////////
   // Reporting
   ////////////////////////////////////////

   task automatic stopFailed();
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic abortRun(input string reason);
      $display("%s", reason);
      stopFailed();
   endtask

   task automatic showMismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stopFailed();
   endtask

   ////////////////////////////////////////
   // Stimulus and reference
   ////////////////////////////////////////

   task automatic drawPixel();
      logic [31:0] r;
      r = $urandom;
      pixel      = r[17:0];
      sync.hsync = r[18];
      sync.vsync = r[19];
      sync.de    = ($urandom_range(7) != 0);  // One in eight blanked
   endtask

   // Rebuilds one pixel from its three lane words
   function automatic sample_t unpackPixel(input laneWord_t w0, input laneWord_t w1,
                                           input laneWord_t w2);
      sample_t s;
      s.pix.red   = w0[5:0];
      s.pix.green = {w1[4:0], w0[6]};
      s.pix.blue  = {w2[3:0], w1[6:5]};
      s.sy.hsync  = w2[4];
      s.sy.vsync  = w2[5];
      s.sy.de     = w2[6];
      return s;
   endfunction

   function automatic sample_t blanked(input sample_t s);
      sample_t b;
      b = s;
      if (!s.sy.de)
         b.pix = '0;       // Blanking drops the colors and keeps the syncs
      return b;
   endfunction

   task automatic checkNext(input sample_t got);
      sample_t exp;
      if (checked >= NUM_PIXELS)
         return;
      assert (expQ.size() > 0) else abortRun("lane data arrived with no pixel pending");
      exp = blanked(expQ.pop_front());
      if (!exp.sy.de)
      begin
         assert (got.pix == '0) else showMismatch("blanked color", 32'(got.pix), 32'd0);
      end
      assert (got.pix.red == exp.pix.red)
         else showMismatch("red", 32'(got.pix.red), 32'(exp.pix.red));
      assert (got.pix.green == exp.pix.green)
         else showMismatch("green", 32'(got.pix.green), 32'(exp.pix.green));
      assert (got.pix.blue == exp.pix.blue)
         else showMismatch("blue", 32'(got.pix.blue), 32'(exp.pix.blue));
      assert (got.sy == exp.sy) else showMismatch("sync", 32'(got.sy), 32'(exp.sy));
      checked++;
   endtask

   ////////////////////////////////////////
   // Lane deserializer
   ////////////////////////////////////////

   always @(negedge clk)
   begin
      sample_t gotA;
      sample_t gotB;
      if (!rst && linkActive)
      begin
         for (int l = 0; l < `LVDS_LANES; l++)
            hist[l] = {lanePairs[l].late, lanePairs[l].early, hist[l][13:2]};
         sinceFrame++;
         assert (sinceFrame <= 2 * `LVDS_PHASES) else abortRun("no clock lane frame found");
         if (hist[3] == CLK_FRAME)    // Window boundary
         begin
            assert (frames == 0 || sinceFrame == `LVDS_PHASES)
               else abortRun("clock lane frame spacing broken");
            sinceFrame = 0;
            frames++;
            gotA = unpackPixel(hist[0][6:0], hist[1][6:0], hist[2][6:0]);
            gotB = unpackPixel(hist[0][13:7], hist[1][13:7], hist[2][13:7]);
            checkNext(gotA);
            checkNext(gotB);
         end
      end
   end

   // Failure flags of the bound property module
   always @(negedge clk)
      assert (!uut.uProps.anyFail) else abortRun("property assertion failed");

   initial
   begin
      #(TIMEOUT_NS);
      abortRun("timeout, pixels still missing on the lanes");
   end

   initial
   begin
      logic reqSeen;
      void'($urandom(71));
      rst = 1'b1;
      drawPixel();
      repeat (3) @(posedge clk);
      #1 rst = 1'b0;
      while (sent < NUM_PIXELS)
      begin
         @(negedge clk);
         reqSeen = pixelReq;
         @(posedge clk);
         #1;
         if (reqSeen)                 // Pixel taken at that edge
         begin
            expQ.push_back({pixel, sync});
            sent++;
            drawPixel();
         end
      end
      wait (checked == NUM_PIXELS);
      if (uut.uProps.anyFail)
         abortRun("property assertion failed");
      else
      begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

// File: verilog.f
+incdir+include
src/linkPkg.sv
src/pixelPkg.sv
src/phaseGen.sv
src/pixelMapper.sv
src/laneSerializer.sv
src/lvdsTransmitter.sv
dv/lvdsTx_props.sv
dv/lvdsTb.sv

// File: Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -j 0
TOP      = lvdsTb
FILELIST = verilog.f
SIMARGS  = +verilator+error+limit+100
PASS     = ALL CHECKS PASSED

OBJDIR  = obj_dir
BIN     = $(OBJDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIMARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)
